// ==== include/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// first fetch address out of reset
`define CPU_RESET_PC 32'h1c00_0000

`define NUM_REGS 32

// inst[31:15] of the three-register ops
`define OP_ADD_W 17'h00020
`define OP_SUB_W 17'h00022
`define OP_NOR   17'h00028
`define OP_AND   17'h00029
`define OP_OR    17'h0002a
`define OP_XOR   17'h0002b

// inst[31:22]
`define OP_ADDI_W 10'h00a
`define OP_LD_W   10'h0a2
`define OP_ST_W   10'h0a6

`define OP_LU12I_W 7'h0a // inst[31:25]

// inst[31:26]
`define OP_B   6'h14
`define OP_BEQ 6'h16
`define OP_BNE 6'h17

`endif

// ==== hdl/cpu_pkg.sv ====
package cpu_pkg;

    typedef logic [31:0] word_t; // data, address or instruction
    typedef logic [4:0] reg_addr_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_lui // passes the shifted si20 through
    } alu_op_t;

    // operand source, newest stage first after the register file
    typedef enum logic [1:0] {
        fwd_rf,
        fwd_ex,
        fwd_mem,
        fwd_wb
    } fwd_sel_t;

endpackage

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module fetch_unit (
    input  logic           clk,
    input  logic           reset,
    input  logic           id_allowin,
    input  logic           br_taken,
    input  cpu_pkg::word_t br_target,
    output cpu_pkg::word_t pc,
    output logic           inst_sram_en,
    output cpu_pkg::word_t inst_sram_addr
);

    cpu_pkg::word_t next_pc;

    assign next_pc = br_taken ? br_target : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `CPU_RESET_PC;
        end else if (id_allowin) begin // pc only moves when ID takes the fetch
            pc <= next_pc;
        end
    end

    assign inst_sram_en   = id_allowin;
    assign inst_sram_addr = pc; // data shows up in ID next cycle

    // branch targets come from decode, reset pc from the header
    pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

// ==== hdl/decode_unit.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module decode_unit (
    input  logic                clk,
    input  logic                reset,
    input  cpu_pkg::word_t      pc,
    input  cpu_pkg::word_t      inst,
    input  cpu_pkg::word_t      rj_value,
    input  cpu_pkg::word_t      rkd_value,
    input  logic                load_stall,
    input  logic                ex_allowin,
    output logic                id_allowin,
    output logic                br_taken,
    output cpu_pkg::word_t      br_target,
    output cpu_pkg::reg_addr_t  rj,
    output cpu_pkg::reg_addr_t  rk_or_rd,
    output logic                need_rj,
    output logic                need_rkd,
    output logic                ex_valid_in,
    output cpu_pkg::alu_op_t    ex_op,
    output cpu_pkg::word_t      ex_src1,
    output cpu_pkg::word_t      ex_src2,
    output cpu_pkg::word_t      ex_store_data,
    output cpu_pkg::reg_addr_t  ex_dest_in,
    output logic                ex_wen_in,
    output logic                ex_load_in,
    output logic                ex_store_in,
    output cpu_pkg::word_t      ex_pc_in
);

    logic           id_valid;
    cpu_pkg::word_t id_pc;
    logic           id_ready_go;
    logic           inst_add_w, inst_sub_w, inst_and, inst_or, inst_xor, inst_nor;
    logic           inst_addi_w, inst_ld_w, inst_st_w, inst_lu12i_w;
    logic           inst_b, inst_beq, inst_bne;
    logic           is_3r;
    logic           src_reg_is_rd;
    cpu_pkg::word_t imm;
    cpu_pkg::word_t br_offs;
    logic           rj_eq_rkd;

    // major opcode fields
    assign inst_add_w   = inst[31:15] == `OP_ADD_W;
    assign inst_sub_w   = inst[31:15] == `OP_SUB_W;
    assign inst_and     = inst[31:15] == `OP_AND;
    assign inst_or      = inst[31:15] == `OP_OR;
    assign inst_xor     = inst[31:15] == `OP_XOR;
    assign inst_nor     = inst[31:15] == `OP_NOR;
    assign inst_addi_w  = inst[31:22] == `OP_ADDI_W;
    assign inst_ld_w    = inst[31:22] == `OP_LD_W;
    assign inst_st_w    = inst[31:22] == `OP_ST_W;
    assign inst_lu12i_w = inst[31:25] == `OP_LU12I_W;
    assign inst_b       = inst[31:26] == `OP_B;
    assign inst_beq     = inst[31:26] == `OP_BEQ;
    assign inst_bne     = inst[31:26] == `OP_BNE;

    assign is_3r         = inst_add_w | inst_sub_w | inst_and | inst_or | inst_xor | inst_nor;
    assign src_reg_is_rd = inst_st_w | inst_beq | inst_bne; // second read port takes rd

    assign rj       = inst[9:5];
    assign rk_or_rd = src_reg_is_rd ? inst[4:0] : inst[14:10];
    assign need_rj  = id_valid & (is_3r | inst_addi_w | inst_ld_w | src_reg_is_rd);
    assign need_rkd = id_valid & (is_3r | src_reg_is_rd);

    assign imm = inst_lu12i_w ? {inst[24:5], 12'b0} : {{20{inst[21]}}, inst[21:10]};

    // offs26 for b, offs16 otherwise
    assign br_offs = inst_b ? {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00}
                            : {{14{inst[25]}}, inst[25:10], 2'b00};

    assign rj_eq_rkd = rj_value == rkd_value;
    assign br_taken  = id_valid & id_ready_go &
                       (inst_b | (inst_beq & rj_eq_rkd) | (inst_bne & ~rj_eq_rkd));
    assign br_target = id_pc + br_offs;

    assign id_ready_go = ~load_stall;
    assign id_allowin  = ex_allowin & (~id_valid | id_ready_go);

    always_ff @(posedge clk) begin
        if (reset) begin
            id_valid <= 1'b0;
        end else if (id_allowin) begin
            id_valid <= ~br_taken; // drop the fetch behind a taken branch
        end
    end

    always_ff @(posedge clk) begin
        if (id_allowin) begin
            id_pc <= pc;
        end
    end

    always_comb begin
        if (inst_sub_w)        ex_op = cpu_pkg::alu_sub;
        else if (inst_and)     ex_op = cpu_pkg::alu_and;
        else if (inst_or)      ex_op = cpu_pkg::alu_or;
        else if (inst_xor)     ex_op = cpu_pkg::alu_xor;
        else if (inst_nor)     ex_op = cpu_pkg::alu_nor;
        else if (inst_lu12i_w) ex_op = cpu_pkg::alu_lui;
        else                   ex_op = cpu_pkg::alu_add; // add.w, addi.w and address calc
    end

    assign ex_valid_in   = id_valid & id_ready_go; // stall leaves a bubble
    assign ex_src1       = rj_value;
    assign ex_src2       = is_3r ? rkd_value : imm;
    assign ex_store_data = rkd_value;
    assign ex_dest_in    = inst[4:0];
    assign ex_wen_in     = is_3r | inst_addi_w | inst_lu12i_w | inst_ld_w;
    assign ex_load_in    = inst_ld_w;
    assign ex_store_in   = inst_st_w;
    assign ex_pc_in      = id_pc;

    one_match: assert property (@(posedge clk) disable iff (reset)
        id_valid |-> $onehot0({inst_add_w, inst_sub_w, inst_and, inst_or, inst_xor, inst_nor,
                               inst_addi_w, inst_ld_w, inst_st_w, inst_lu12i_w,
                               inst_b, inst_beq, inst_bne}));

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module reg_file (
    input  logic               clk,
    input  cpu_pkg::reg_addr_t raddr1,
    input  cpu_pkg::reg_addr_t raddr2,
    input  logic               we,
    input  cpu_pkg::reg_addr_t waddr,
    input  cpu_pkg::word_t     wdata,
    output cpu_pkg::word_t     rdata1,
    output cpu_pkg::word_t     rdata2
);

    cpu_pkg::word_t regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 reads as zero, same-cycle writes come through the bypass
    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

// ==== hdl/bypass_unit.sv ====
`timescale 1ns/1ps

module bypass_unit (
    input  cpu_pkg::reg_addr_t rj,
    input  cpu_pkg::reg_addr_t rk_or_rd,
    input  logic               need_rj,
    input  logic               need_rkd,
    input  cpu_pkg::word_t     rf_rdata1,
    input  cpu_pkg::word_t     rf_rdata2,
    input  cpu_pkg::reg_addr_t ex_dest,
    input  logic               ex_wen,
    input  logic               ex_is_load,
    input  cpu_pkg::word_t     ex_result,
    input  cpu_pkg::reg_addr_t mem_dest,
    input  logic               mem_wen,
    input  logic               mem_is_load,
    input  cpu_pkg::word_t     mem_result,
    input  cpu_pkg::reg_addr_t wb_dest,
    input  logic               wb_wen,
    input  cpu_pkg::word_t     wb_result,
    output cpu_pkg::word_t     rj_value,
    output cpu_pkg::word_t     rkd_value,
    output logic               load_stall
);

    cpu_pkg::fwd_sel_t rj_sel;
    cpu_pkg::fwd_sel_t rkd_sel;
    logic              rj_load_hit;
    logic              rkd_load_hit;

    // newest producer wins, r0 never forwarded
    function automatic cpu_pkg::fwd_sel_t pick_src(input cpu_pkg::reg_addr_t src);
        if (src == 5'd0)                     return cpu_pkg::fwd_rf;
        else if (ex_wen && ex_dest == src)   return cpu_pkg::fwd_ex;
        else if (mem_wen && mem_dest == src) return cpu_pkg::fwd_mem;
        else if (wb_wen && wb_dest == src)   return cpu_pkg::fwd_wb;
        else                                 return cpu_pkg::fwd_rf;
    endfunction

    function automatic cpu_pkg::word_t fwd_mux(input cpu_pkg::fwd_sel_t sel,
                                               input cpu_pkg::word_t rf_data);
        case (sel)
            cpu_pkg::fwd_ex:  return ex_result;
            cpu_pkg::fwd_mem: return mem_result;
            cpu_pkg::fwd_wb:  return wb_result;
            default:          return rf_data;
        endcase
    endfunction

    assign rj_sel    = pick_src(rj);
    assign rkd_sel   = pick_src(rk_or_rd);
    assign rj_value  = fwd_mux(rj_sel, rf_rdata1);
    assign rkd_value = fwd_mux(rkd_sel, rf_rdata2);

    // load data only exists in WB
    assign rj_load_hit  = (rj_sel == cpu_pkg::fwd_ex && ex_is_load) ||
                          (rj_sel == cpu_pkg::fwd_mem && mem_is_load);
    assign rkd_load_hit = (rkd_sel == cpu_pkg::fwd_ex && ex_is_load) ||
                          (rkd_sel == cpu_pkg::fwd_mem && mem_is_load);
    assign load_stall   = (need_rj && rj_load_hit) || (need_rkd && rkd_load_hit);

endmodule

// ==== hdl/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit (
    input  logic               clk,
    input  logic               reset,
    input  logic               ex_valid_in,
    input  cpu_pkg::alu_op_t   ex_op,
    input  cpu_pkg::word_t     ex_src1,
    input  cpu_pkg::word_t     ex_src2,
    input  cpu_pkg::word_t     ex_store_data,
    input  cpu_pkg::reg_addr_t ex_dest_in,
    input  logic               ex_wen_in,
    input  logic               ex_load_in,
    input  logic               ex_store_in,
    input  cpu_pkg::word_t     ex_pc_in,
    input  logic               mem_allowin,
    output logic               ex_allowin,
    output cpu_pkg::reg_addr_t ex_dest,
    output logic               ex_wen,
    output logic               ex_is_load,
    output cpu_pkg::word_t     ex_result,
    output logic               mem_valid,
    output cpu_pkg::reg_addr_t mem_dest,
    output logic               mem_wen,
    output logic               mem_is_load,
    output logic               mem_store,
    output cpu_pkg::word_t     mem_addr_result,
    output cpu_pkg::word_t     mem_store_data,
    output cpu_pkg::word_t     mem_pc
);

    logic             ex_valid;
    cpu_pkg::alu_op_t op_r;
    cpu_pkg::word_t   src1_r, src2_r, store_data_r, pc_r;
    logic             wen_r, store_r;

    assign ex_allowin = mem_allowin; // EX always finishes in one cycle

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid  <= 1'b0;
            mem_valid <= 1'b0;
        end else begin
            if (ex_allowin) ex_valid <= ex_valid_in;
            if (mem_allowin) mem_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_allowin && ex_valid_in) begin
            op_r         <= ex_op;
            src1_r       <= ex_src1;
            src2_r       <= ex_src2;
            store_data_r <= ex_store_data;
            ex_dest      <= ex_dest_in;
            wen_r        <= ex_wen_in;
            ex_is_load   <= ex_load_in;
            store_r      <= ex_store_in;
            pc_r         <= ex_pc_in;
        end
        if (mem_allowin && ex_valid) begin
            mem_dest        <= ex_dest;
            mem_wen         <= wen_r;
            mem_is_load     <= ex_is_load;
            mem_store       <= store_r;
            mem_addr_result <= ex_result;
            mem_store_data  <= store_data_r;
            mem_pc          <= pc_r;
        end
    end

    always_comb begin
        case (op_r)
            cpu_pkg::alu_sub: ex_result = src1_r - src2_r;
            cpu_pkg::alu_and: ex_result = src1_r & src2_r;
            cpu_pkg::alu_or:  ex_result = src1_r | src2_r;
            cpu_pkg::alu_xor: ex_result = src1_r ^ src2_r;
            cpu_pkg::alu_nor: ex_result = ~(src1_r | src2_r);
            cpu_pkg::alu_lui: ex_result = src2_r;
            default:          ex_result = src1_r + src2_r;
        endcase
    end

    assign ex_wen = ex_valid & wen_r; // bubbles never forward

endmodule

// ==== hdl/mem_wb_unit.sv ====
`timescale 1ns/1ps

module mem_wb_unit (
    input  logic               clk,
    input  logic               reset,
    input  logic               mem_valid,
    input  cpu_pkg::reg_addr_t mem_dest,
    input  logic               mem_gr_we,
    input  logic               mem_is_load,
    input  logic               mem_store,
    input  cpu_pkg::word_t     mem_addr_result,
    input  cpu_pkg::word_t     mem_store_data,
    input  cpu_pkg::word_t     mem_pc,
    input  cpu_pkg::word_t     data_sram_rdata,
    output logic               mem_allowin,
    output logic               mem_wen,
    output cpu_pkg::word_t     mem_result,
    output cpu_pkg::reg_addr_t wb_dest,
    output logic               wb_wen,
    output cpu_pkg::word_t     wb_result,
    output logic               data_sram_en,
    output logic [3:0]         data_sram_we,
    output cpu_pkg::word_t     data_sram_addr,
    output cpu_pkg::word_t     data_sram_wdata,
    output logic               rf_we,
    output cpu_pkg::reg_addr_t rf_waddr,
    output cpu_pkg::word_t     rf_wdata,
    output cpu_pkg::word_t     debug_wb_pc,
    output logic               debug_wb_rf_we,
    output cpu_pkg::reg_addr_t debug_wb_rf_wnum,
    output cpu_pkg::word_t     debug_wb_rf_wdata
);

    logic           core_run; // goes high one cycle after reset drops
    logic           wb_valid;
    logic           wb_gr_we;
    logic           wb_is_load;
    cpu_pkg::word_t wb_alu_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            core_run <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            core_run <= 1'b1;
            wb_valid <= mem_valid; // WB never stalls
        end
    end

    assign mem_allowin = core_run; // MEM and WB are always ready

    assign data_sram_en    = mem_valid & (mem_is_load | mem_store);
    assign data_sram_we    = {4{mem_valid & mem_store}}; // st.w writes all lanes
    assign data_sram_addr  = {mem_addr_result[31:2], 2'b00};
    assign data_sram_wdata = mem_store_data;

    assign mem_wen    = mem_valid & mem_gr_we;
    assign mem_result = mem_addr_result;

    always_ff @(posedge clk) begin
        if (mem_valid) begin
            wb_dest       <= mem_dest;
            wb_gr_we      <= mem_gr_we;
            wb_is_load    <= mem_is_load;
            wb_alu_result <= mem_addr_result;
            debug_wb_pc   <= mem_pc;
        end
    end

    assign wb_wen    = wb_valid & wb_gr_we;
    assign wb_result = wb_is_load ? data_sram_rdata : wb_alu_result; // sram read lands here

    assign rf_we    = wb_wen;
    assign rf_waddr = wb_dest;
    assign rf_wdata = wb_result;

    assign debug_wb_rf_we    = wb_wen;
    assign debug_wb_rf_wnum  = wb_dest;
    assign debug_wb_rf_wdata = wb_result;

    we_needs_en: assert property (@(posedge clk) disable iff (reset)
        data_sram_we != 4'b0 |-> data_sram_en);

endmodule

// ==== hdl/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top (
    input  logic               clk,
    input  logic               reset,
    input  cpu_pkg::word_t     inst_sram_rdata,
    input  cpu_pkg::word_t     data_sram_rdata,
    output logic               inst_sram_en,
    output cpu_pkg::word_t     inst_sram_addr,
    output logic               data_sram_en,
    output logic [3:0]         data_sram_we,
    output cpu_pkg::word_t     data_sram_addr,
    output cpu_pkg::word_t     data_sram_wdata,
    output cpu_pkg::word_t     debug_wb_pc,
    output logic               debug_wb_rf_we,
    output cpu_pkg::reg_addr_t debug_wb_rf_wnum,
    output cpu_pkg::word_t     debug_wb_rf_wdata
);

    logic               id_allowin, ex_allowin, mem_allowin;
    logic               br_taken;
    cpu_pkg::word_t     br_target, pc;
    cpu_pkg::reg_addr_t rj, rk_or_rd;
    logic               need_rj, need_rkd, load_stall;
    cpu_pkg::word_t     rj_value, rkd_value, rf_rdata1, rf_rdata2;
    logic               ex_valid_in, ex_wen_in, ex_load_in, ex_store_in;
    cpu_pkg::alu_op_t   ex_op;
    cpu_pkg::word_t     ex_src1, ex_src2, ex_store_data, ex_pc_in;
    cpu_pkg::reg_addr_t ex_dest_in, ex_dest, mem_dest, wb_dest, rf_waddr;
    logic               ex_wen, ex_is_load, mem_wen, mem_is_load, wb_wen;
    cpu_pkg::word_t     ex_result, mem_result, wb_result, rf_wdata;
    logic               mem_valid, mem_gr_we, mem_store, rf_we;
    cpu_pkg::word_t     mem_addr_result, mem_store_data, mem_pc;

    fetch_unit u_fetch (
        .clk(clk), .reset(reset), .id_allowin(id_allowin),
        .br_taken(br_taken), .br_target(br_target), .pc(pc),
        .inst_sram_en(inst_sram_en), .inst_sram_addr(inst_sram_addr)
    );

    decode_unit u_decode (
        .clk(clk), .reset(reset), .pc(pc), .inst(inst_sram_rdata),
        .rj_value(rj_value), .rkd_value(rkd_value), .load_stall(load_stall),
        .ex_allowin(ex_allowin), .id_allowin(id_allowin),
        .br_taken(br_taken), .br_target(br_target), .rj(rj), .rk_or_rd(rk_or_rd),
        .need_rj(need_rj), .need_rkd(need_rkd), .ex_valid_in(ex_valid_in),
        .ex_op(ex_op), .ex_src1(ex_src1), .ex_src2(ex_src2),
        .ex_store_data(ex_store_data), .ex_dest_in(ex_dest_in), .ex_wen_in(ex_wen_in),
        .ex_load_in(ex_load_in), .ex_store_in(ex_store_in), .ex_pc_in(ex_pc_in)
    );

    reg_file u_reg_file (
        .clk(clk), .raddr1(rj), .raddr2(rk_or_rd), .we(rf_we),
        .waddr(rf_waddr), .wdata(rf_wdata), .rdata1(rf_rdata1), .rdata2(rf_rdata2)
    );

    bypass_unit u_bypass (
        .rj(rj), .rk_or_rd(rk_or_rd), .need_rj(need_rj), .need_rkd(need_rkd),
        .rf_rdata1(rf_rdata1), .rf_rdata2(rf_rdata2),
        .ex_dest(ex_dest), .ex_wen(ex_wen), .ex_is_load(ex_is_load), .ex_result(ex_result),
        .mem_dest(mem_dest), .mem_wen(mem_wen), .mem_is_load(mem_is_load),
        .mem_result(mem_result), .wb_dest(wb_dest), .wb_wen(wb_wen), .wb_result(wb_result),
        .rj_value(rj_value), .rkd_value(rkd_value), .load_stall(load_stall)
    );

    execute_unit u_execute (
        .clk(clk), .reset(reset), .ex_valid_in(ex_valid_in), .ex_op(ex_op),
        .ex_src1(ex_src1), .ex_src2(ex_src2), .ex_store_data(ex_store_data),
        .ex_dest_in(ex_dest_in), .ex_wen_in(ex_wen_in), .ex_load_in(ex_load_in),
        .ex_store_in(ex_store_in), .ex_pc_in(ex_pc_in), .mem_allowin(mem_allowin),
        .ex_allowin(ex_allowin), .ex_dest(ex_dest), .ex_wen(ex_wen),
        .ex_is_load(ex_is_load), .ex_result(ex_result), .mem_valid(mem_valid),
        .mem_dest(mem_dest), .mem_wen(mem_gr_we), .mem_is_load(mem_is_load),
        .mem_store(mem_store), .mem_addr_result(mem_addr_result),
        .mem_store_data(mem_store_data), .mem_pc(mem_pc)
    );

    mem_wb_unit u_mem_wb (
        .clk(clk), .reset(reset), .mem_valid(mem_valid), .mem_dest(mem_dest),
        .mem_gr_we(mem_gr_we), .mem_is_load(mem_is_load), .mem_store(mem_store),
        .mem_addr_result(mem_addr_result), .mem_store_data(mem_store_data),
        .mem_pc(mem_pc), .data_sram_rdata(data_sram_rdata), .mem_allowin(mem_allowin),
        .mem_wen(mem_wen), .mem_result(mem_result), .wb_dest(wb_dest),
        .wb_wen(wb_wen), .wb_result(wb_result), .data_sram_en(data_sram_en),
        .data_sram_we(data_sram_we), .data_sram_addr(data_sram_addr),
        .data_sram_wdata(data_sram_wdata), .rf_we(rf_we), .rf_waddr(rf_waddr),
        .rf_wdata(rf_wdata), .debug_wb_pc(debug_wb_pc), .debug_wb_rf_we(debug_wb_rf_we),
        .debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

endmodule

// ==== tb/cpu_tb.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_tb;

    localparam int PROG_LEN       = 200; // setup plus random part, b-to-self sits after it
    localparam int SETUP_LEN      = 14;
    localparam int TIMEOUT_CYCLES = PROG_LEN * 4 + 100;

    // pc of the parking b, its arrival in WB ends the program
    localparam cpu_pkg::word_t PARK_PC = `CPU_RESET_PC + PROG_LEN * 4;

    localparam int K_ADD   = 0;
    localparam int K_SUB   = 1;
    localparam int K_AND   = 2;
    localparam int K_OR    = 3;
    localparam int K_XOR   = 4;
    localparam int K_NOR   = 5;
    localparam int K_ADDI  = 6;
    localparam int K_LU12I = 7;
    localparam int K_LD    = 8;
    localparam int K_ST    = 9;
    localparam int K_BEQ   = 10;
    localparam int K_BNE   = 11;
    localparam int K_B     = 12;

    logic               clk;
    logic               reset;
    cpu_pkg::word_t     inst_sram_rdata;
    cpu_pkg::word_t     data_sram_rdata;
    logic               inst_sram_en;
    cpu_pkg::word_t     inst_sram_addr;
    logic               data_sram_en;
    logic [3:0]         data_sram_we;
    cpu_pkg::word_t     data_sram_addr;
    cpu_pkg::word_t     data_sram_wdata;
    cpu_pkg::word_t     debug_wb_pc;
    logic               debug_wb_rf_we;
    cpu_pkg::reg_addr_t debug_wb_rf_wnum;
    cpu_pkg::word_t     debug_wb_rf_wdata;

    cpu_pkg::word_t imem [256];
    cpu_pkg::word_t dmem [64];

    // generated program, one entry per slot
    int             p_kind [PROG_LEN + 1];
    logic [4:0]     p_rd   [PROG_LEN + 1];
    logic [4:0]     p_rj   [PROG_LEN + 1];
    logic [4:0]     p_rk   [PROG_LEN + 1];
    cpu_pkg::word_t p_imm  [PROG_LEN + 1];

    // expected write-back trace from the model
    cpu_pkg::word_t exp_pc   [PROG_LEN];
    logic [4:0]     exp_num  [PROG_LEN];
    cpu_pkg::word_t exp_data [PROG_LEN];
    string          exp_name [PROG_LEN];
    int             exp_count;
    int             checked;
    int             cycles;
    logic           first_fetch_seen;

    cpu_top u_dut (
        .clk(clk), .reset(reset),
        .inst_sram_rdata(inst_sram_rdata), .data_sram_rdata(data_sram_rdata),
        .inst_sram_en(inst_sram_en), .inst_sram_addr(inst_sram_addr),
        .data_sram_en(data_sram_en), .data_sram_we(data_sram_we),
        .data_sram_addr(data_sram_addr), .data_sram_wdata(data_sram_wdata),
        .debug_wb_pc(debug_wb_pc), .debug_wb_rf_we(debug_wb_rf_we),
        .debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // synchronous SRAMs, data one cycle after the enable
    always @(posedge clk) begin
        if (inst_sram_en) inst_sram_rdata <= imem[inst_sram_addr[9:2]];
    end

    always @(posedge clk) begin
        if (data_sram_en) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (data_sram_we[lane]) begin
                    dmem[data_sram_addr[7:2]][8*lane +: 8] <= data_sram_wdata[8*lane +: 8];
                end
            end
            data_sram_rdata <= dmem[data_sram_addr[7:2]];
        end
    end

    function automatic cpu_pkg::word_t fill_word(input int i);
        return (32'h9e37_79b9 * (i + 1)) ^ i;
    endfunction

    function automatic cpu_pkg::word_t encode(input int kind, input logic [4:0] rd,
                                              input logic [4:0] rj, input logic [4:0] rk,
                                              input cpu_pkg::word_t imm);
        case (kind)
            K_ADD:   return {`OP_ADD_W, rk, rj, rd};
            K_SUB:   return {`OP_SUB_W, rk, rj, rd};
            K_AND:   return {`OP_AND, rk, rj, rd};
            K_OR:    return {`OP_OR, rk, rj, rd};
            K_XOR:   return {`OP_XOR, rk, rj, rd};
            K_NOR:   return {`OP_NOR, rk, rj, rd};
            K_ADDI:  return {`OP_ADDI_W, imm[11:0], rj, rd};
            K_LU12I: return {`OP_LU12I_W, imm[19:0], rd};
            K_LD:    return {`OP_LD_W, imm[11:0], rj, rd};
            K_ST:    return {`OP_ST_W, imm[11:0], rj, rd};
            K_BEQ:   return {`OP_BEQ, imm[15:0], rj, rd};
            K_BNE:   return {`OP_BNE, imm[15:0], rj, rd};
            default: return {`OP_B, imm[15:0], imm[25:16]}; // offs26 split
        endcase
    endfunction

    function automatic string kind_name(input int kind);
        case (kind)
            K_ADD:   return "add.w";
            K_SUB:   return "sub.w";
            K_AND:   return "and";
            K_OR:    return "or";
            K_XOR:   return "xor";
            K_NOR:   return "nor";
            K_ADDI:  return "addi.w";
            K_LU12I: return "lu12i.w";
            K_LD:    return "ld.w";
            default: return "other";
        endcase
    endfunction

    task automatic stop_on_error(input string detail);
        $display("TESTBENCH FAILED");
        $display("%s", detail);
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic place(input int i, input int kind, input logic [4:0] rd,
                         input logic [4:0] rj, input logic [4:0] rk, input cpu_pkg::word_t imm);
        p_kind[i] = kind;
        p_rd[i]   = rd;
        p_rj[i]   = rj;
        p_rk[i]   = rk;
        p_imm[i]  = imm;
        imem[i]   = encode(kind, rd, rj, rk, imm);
    endtask

    task automatic build_program;
        int             i;
        int             kind;
        int             off;
        logic [4:0]     rd, rj, rk;
        cpu_pkg::word_t imm;
        for (i = 0; i < 256; i++) imem[i] = 32'h0;
        // r1..r7 get a full random word first
        for (i = 0; i < SETUP_LEN; i++) begin
            rd = 5'(i / 2 + 1);
            if (i % 2 == 0) place(i, K_LU12I, rd, 5'd0, 5'd0, $urandom);
            else place(i, K_ADDI, rd, rd, 5'd0, $urandom);
        end
        for (i = SETUP_LEN; i < PROG_LEN; i++) begin
            kind = $urandom % 13;
            rd   = 5'($urandom % 8); // r0..r7 keeps dependences dense
            rj   = 5'($urandom % 8);
            rk   = 5'($urandom % 8);
            imm  = $urandom;
            if (kind == K_LD || kind == K_ST) begin
                rj  = 5'd0;
                imm = ($urandom % 64) * 4;
            end else if (kind >= K_BEQ) begin
                off = 1 + $urandom % 4;
                if (i + off > PROG_LEN) off = PROG_LEN - i;
                imm = off;
            end
            place(i, kind, rd, rj, rk, imm);
        end
        place(PROG_LEN, K_B, 5'd0, 5'd0, 5'd0, 32'd0); // parks the core
    endtask

    // sequential ISA model
    task automatic run_model;
        cpu_pkg::word_t mregs [`NUM_REGS];
        cpu_pkg::word_t mdmem [64];
        cpu_pkg::word_t a, b, d, simm, res, addr;
        int             idx, next, i;
        logic           wr;
        for (i = 0; i < `NUM_REGS; i++) mregs[i] = 32'h0;
        for (i = 0; i < 64; i++) mdmem[i] = fill_word(i);
        exp_count = 0;
        idx = 0;
        while (idx < PROG_LEN) begin
            a    = mregs[p_rj[idx]];
            b    = mregs[p_rk[idx]];
            d    = mregs[p_rd[idx]];
            simm = {{20{p_imm[idx][11]}}, p_imm[idx][11:0]};
            addr = a + simm;
            next = idx + 1;
            wr   = 1'b1;
            res  = 32'h0;
            case (p_kind[idx])
                K_ADD:   res = a + b;
                K_SUB:   res = a - b;
                K_AND:   res = a & b;
                K_OR:    res = a | b;
                K_XOR:   res = a ^ b;
                K_NOR:   res = ~(a | b);
                K_ADDI:  res = a + simm;
                K_LU12I: res = {p_imm[idx][19:0], 12'h000};
                K_LD:    res = mdmem[addr[7:2]];
                K_ST: begin
                    mdmem[addr[7:2]] = d;
                    wr = 1'b0;
                end
                K_BEQ: begin
                    wr = 1'b0;
                    if (a == d) next = idx + int'(p_imm[idx]);
                end
                K_BNE: begin
                    wr = 1'b0;
                    if (a != d) next = idx + int'(p_imm[idx]);
                end
                default: begin
                    wr   = 1'b0;
                    next = idx + int'(p_imm[idx]);
                end
            endcase
            if (wr && p_rd[idx] != 5'd0) begin
                mregs[p_rd[idx]]    = res;
                exp_pc[exp_count]   = `CPU_RESET_PC + idx * 4;
                exp_num[exp_count]  = p_rd[idx];
                exp_data[exp_count] = res;
                exp_name[exp_count] = kind_name(p_kind[idx]);
                exp_count++;
            end
            idx = next;
        end
    endtask

    task automatic check_trace;
        string name;
        if (debug_wb_rf_we && debug_wb_rf_wnum != 5'd0) begin
            assert (checked < exp_count)
            else stop_on_error("a register write-back appeared after the last expected one");
            name = $sformatf("trace %0d %s", checked, exp_name[checked]);
            assert (debug_wb_pc == exp_pc[checked])
            else stop_on_error($sformatf("Fail %s pc: expected %h, actual %h",
                                         name, exp_pc[checked], debug_wb_pc));
            assert (debug_wb_rf_wnum == exp_num[checked])
            else stop_on_error($sformatf("Fail %s wnum: expected %0d, actual %0d",
                                         name, exp_num[checked], debug_wb_rf_wnum));
            assert (debug_wb_rf_wdata == exp_data[checked])
            else stop_on_error($sformatf("Fail %s wdata: expected %h, actual %h",
                                         name, exp_data[checked], debug_wb_rf_wdata));
            checked++;
        end
    endtask

    initial begin
        reset            = 1'b1;
        inst_sram_rdata  = 32'h0;
        data_sram_rdata  = 32'h0;
        checked          = 0;
        cycles           = 0;
        first_fetch_seen = 1'b0;
        void'($urandom(72129));
        build_program();
        run_model();
        for (int i = 0; i < 64; i++) dmem[i] = fill_word(i);

        repeat (5) begin
            @(negedge clk);
            assert (!inst_sram_en && !data_sram_en && !debug_wb_rf_we)
            else stop_on_error("an SRAM enable or the write-back enable was high in reset");
        end
        reset = 1'b0;

        // every older instruction has retired once the parking b sits in WB
        while (debug_wb_pc !== PARK_PC && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
            if (cycles == 1) begin
                assert (!data_sram_en && !debug_wb_rf_we)
                else stop_on_error("data SRAM or write-back active on the first cycle after reset");
            end
            if (!first_fetch_seen && inst_sram_en) begin
                assert (inst_sram_addr == `CPU_RESET_PC)
                else stop_on_error($sformatf("Fail first fetch: expected %h, actual %h",
                                             `CPU_RESET_PC, inst_sram_addr));
                first_fetch_seen = 1'b1;
            end
            check_trace();
        end

        if (checked == exp_count && debug_wb_pc === PARK_PC) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            stop_on_error($sformatf("the trace did not complete, %0d of %0d write-backs in %0d cycles",
                                    checked, exp_count, cycles));
        end
    end

endmodule

// ==== src.f ====
+incdir+include
hdl/cpu_pkg.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/reg_file.sv
hdl/bypass_unit.sv
hdl/execute_unit.sv
hdl/mem_wb_unit.sv
hdl/cpu_top.sv
tb/cpu_tb.sv
